// File: flist.f
+incdir+rtl
rtl/ddr3_intf_pkg.sv
rtl/mem_req_if.sv
rtl/acq_write_path.sv
rtl/fill_header_fifo.sv
rtl/burst_read_path.sv
rtl/ddr3_cmd_ctrl.sv
rtl/ddr3_intf.sv
verification/app_mem_model.sv
verification/ddr3_intf_tb.sv

// File: rtl/acq_write_path.sv
`timescale 1ns/1ps
`default_nettype none

`include "ddr3_intf_defs.svh"

module acq_write_path import ddr3_intf_pkg::*; (
	input  wire                    ddr3_domain_clk,
	input  wire                    rst_n,
	input  wire                    acq_enabled,         // acquisition mode, drain the fifo
	input  wire                    ddr3_wr_fifo_empty,
	input  wire [`DDR3_DATA_W-1:0] ddr3_wr_fifo_dat,    // fwft head, valid while not empty
	input  wire                    hdr_full,            // header fifo cannot take another
	output logic                   ddr3_wr_fifo_rd_en,  // pop strobe
	output logic                   hdr_push,
	output fill_header_t           hdr_word,
	output logic                   ddr3_wr_sync_err,    // sticky framing error
	mem_req_if.requester           wr_req
);

	acq_word_u               word_u;      // fifo head, both views
	logic                    is_hdr;
	logic                    acq_d;       // acq_enabled one cycle late
	logic                    acq_rise;
	logic                    out_valid;   // output register holds a word
	logic [`DDR3_DATA_W-1:0] out_data;
	logic [`DDR3_ADDR_W-1:0] wr_addr;     // next burst address
	logic [31:0]             words_left;  // data words still owed to the last header
	logic [31:0]             cnt_now;     // words_left as seen by this pop

	assign word_u   = ddr3_wr_fifo_dat;
	assign is_hdr   = (word_u.hdr.tag == `FILL_HDR_TAG);
	assign acq_rise = acq_enabled & ~acq_d;

	// a new acquisition must open with a header, so the count starts at zero
	assign cnt_now = acq_rise ? 32'd0 : words_left;

	// pop when the register is free or leaves this cycle
	// a header waits while the header fifo is full
	always_comb begin
		ddr3_wr_fifo_rd_en = acq_enabled && !ddr3_wr_fifo_empty &&
			(!out_valid || wr_req.grant) && !(is_hdr && hdr_full);
	end

	assign hdr_push = ddr3_wr_fifo_rd_en & is_hdr;   // header copied in the pop cycle
	assign hdr_word = word_u.hdr;

	assign wr_req.req   = out_valid;
	assign wr_req.rd    = 1'b0;       // write only
	assign wr_req.addr  = wr_addr;
	assign wr_req.wdata = out_data;

	always_ff @(posedge ddr3_domain_clk) begin
		if (!rst_n) begin
			acq_d     <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			acq_d <= acq_enabled;
			if (ddr3_wr_fifo_rd_en)
				out_valid <= 1'b1;             // req from the next cycle
			else if (wr_req.grant)
				out_valid <= 1'b0;
		end
	end

	// payload, the whole popped word
	always_ff @(posedge ddr3_domain_clk) begin
		if (ddr3_wr_fifo_rd_en)
			out_data <= word_u;
	end

	// burst address, restarts with each acquisition
	always_ff @(posedge ddr3_domain_clk) begin
		if (!rst_n)
			wr_addr <= '0;
		else if (acq_rise)
			wr_addr <= '0;
		else if (wr_req.grant)
			wr_addr <= wr_addr + 1'b1;   // one burst per word
	end

	// framing check
	// header loads the count, data words count it down
	always_ff @(posedge ddr3_domain_clk) begin
		if (!rst_n) begin
			words_left       <= '0;
			ddr3_wr_sync_err <= 1'b0;
		end else begin
			if (acq_rise)
				words_left <= '0;
			if (ddr3_wr_fifo_rd_en) begin
				if (is_hdr) begin
					if (cnt_now != 32'd0)
						ddr3_wr_sync_err <= 1'b1;   // header came early
					words_left <= word_u.hdr.word_count;
				end else if (cnt_now == 32'd0) begin
					ddr3_wr_sync_err <= 1'b1;       // data with no header owed
				end else begin
					words_left <= cnt_now - 32'd1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/burst_read_path.sv
`timescale 1ns/1ps
`default_nettype none

`include "ddr3_intf_defs.svh"

module burst_read_path (
	input  wire                     ddr3_domain_clk,
	input  wire                     rst_n,
	input  wire                     ddr3_rd_one_burst,    // level request from readout
	input  wire  [`DDR3_ADDR_W-1:0] ddr3_rd_burst_addr,
	input  wire                     app_rd_data_valid,    // one cycle pulse
	input  wire  [`DDR3_DATA_W-1:0] app_rd_data,
	output logic                    ddr3_one_burst_rdy,
	output logic [`DDR3_DATA_W-1:0] ddr3_one_burst_data,
	mem_req_if.requester            rd_req
);

	localparam logic [1:0] ST_IDLE = 2'd0;   // armed, wait for a request edge
	localparam logic [1:0] ST_REQ  = 2'd1;   // read pending at the controller
	localparam logic [1:0] ST_WAIT = 2'd2;   // accepted, data not back yet
	localparam logic [1:0] ST_HOLD = 2'd3;   // burst presented until request drops

	logic [1:0]              state;
	logic                    rd_one_d;
	logic [`DDR3_ADDR_W-1:0] rd_addr;

	assign rd_req.req   = (state == ST_REQ);
	assign rd_req.rd    = 1'b1;
	assign rd_req.addr  = rd_addr;
	assign rd_req.wdata = '0;              // reads carry no data

	assign ddr3_one_burst_rdy = (state == ST_HOLD);

	always_ff @(posedge ddr3_domain_clk) begin
		if (!rst_n) begin
			state    <= ST_IDLE;
			rd_one_d <= 1'b0;
		end else begin
			rd_one_d <= ddr3_rd_one_burst;
			case (state)
				ST_IDLE: if (ddr3_rd_one_burst && !rd_one_d) state <= ST_REQ;
				ST_REQ:  if (rd_req.grant)                   state <= ST_WAIT;
				ST_WAIT: if (app_rd_data_valid)              state <= ST_HOLD;
				ST_HOLD: if (!ddr3_rd_one_burst)             state <= ST_IDLE;   // re-arm
				default: state <= ST_IDLE;
			endcase
		end
	end

	// address and returned burst, no reset
	always_ff @(posedge ddr3_domain_clk) begin
		if (state == ST_IDLE && ddr3_rd_one_burst && !rd_one_d)
			rd_addr <= ddr3_rd_burst_addr;     // taken on the request edge
		if (state == ST_WAIT && app_rd_data_valid)
			ddr3_one_burst_data <= app_rd_data;
	end

endmodule

`default_nettype wire

// File: rtl/ddr3_cmd_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "ddr3_intf_defs.svh"

module ddr3_cmd_ctrl (
	input  wire                     ddr3_domain_clk,
	input  wire                     rst_n,
	input  wire                     app_rdy,             // app port takes a command this cycle
	input  wire                     app_rd_data_valid,   // closes the outstanding read
	output logic                    app_cmd_en,
	output logic                    app_cmd_rd,
	output logic [`DDR3_ADDR_W-1:0] app_addr,
	output logic [`DDR3_DATA_W-1:0] app_wdf_data,
	output logic                    app_wdf_wren,
	mem_req_if.ctrl                 wr_req,
	mem_req_if.ctrl                 rd_req
);

	logic rd_outstanding;   // a read is in flight
	logic sel_rd;           // read requester owns the port
	logic accept;

	// reads go first, but only one in flight
	assign sel_rd = rd_req.req && !rd_outstanding;

	always_comb begin
		if (sel_rd) begin
			app_cmd_en   = 1'b1;
			app_cmd_rd   = rd_req.rd;
			app_addr     = rd_req.addr;
			app_wdf_data = rd_req.wdata;
		end else begin
			app_cmd_en   = wr_req.req;
			app_cmd_rd   = wr_req.rd;
			app_addr     = wr_req.addr;
			app_wdf_data = wr_req.wdata;
		end
	end

	assign app_wdf_wren = app_cmd_en && !app_cmd_rd;   // data rides with the write command
	assign accept       = app_cmd_en && app_rdy;

	// grant is acceptance, steered to the owner
	assign rd_req.grant = accept && sel_rd;
	assign wr_req.grant = accept && !sel_rd;

	always_ff @(posedge ddr3_domain_clk) begin
		if (!rst_n)
			rd_outstanding <= 1'b0;
		else if (rd_req.grant && app_cmd_rd)
			rd_outstanding <= 1'b1;
		else if (app_rd_data_valid)
			rd_outstanding <= 1'b0;   // latency is at least two cycles
	end

endmodule

`default_nettype wire

// File: rtl/ddr3_intf.sv
`timescale 1ns/1ps
`default_nettype none

`include "ddr3_intf_defs.svh"

module ddr3_intf import ddr3_intf_pkg::*; (
	input  wire                     ddr3_domain_clk,
	input  wire                     rst_n,
	// acquisition side
	input  wire                     acq_enabled,
	input  wire                     ddr3_wr_fifo_empty,
	input  wire  [`DDR3_DATA_W-1:0] ddr3_wr_fifo_dat,
	output logic                    ddr3_wr_fifo_rd_en,
	output logic                    ddr3_wr_sync_err,
	// readout side
	input  wire                     fill_header_fifo_rd_en,
	output logic                    fill_header_fifo_empty,
	output logic [`DDR3_DATA_W-1:0] fill_header_fifo_out,
	input  wire  [`DDR3_ADDR_W-1:0] ddr3_rd_burst_addr,
	input  wire                     ddr3_rd_one_burst,
	output logic                    ddr3_one_burst_rdy,
	output logic [`DDR3_DATA_W-1:0] ddr3_one_burst_data,
	// application port
	output logic                    app_cmd_en,
	output logic                    app_cmd_rd,
	output logic [`DDR3_ADDR_W-1:0] app_addr,
	output logic [`DDR3_DATA_W-1:0] app_wdf_data,
	output logic                    app_wdf_wren,
	input  wire                     app_rdy,
	input  wire                     app_rd_data_valid,
	input  wire  [`DDR3_DATA_W-1:0] app_rd_data
);

	fill_header_t hdr_word;   // header copy, write path to header fifo
	logic         hdr_push;
	logic         hdr_full;

	mem_req_if wr_req ();
	mem_req_if rd_req ();

	acq_write_path u_acq_write_path (
		.ddr3_domain_clk    (ddr3_domain_clk),
		.rst_n              (rst_n),
		.acq_enabled        (acq_enabled),
		.ddr3_wr_fifo_empty (ddr3_wr_fifo_empty),
		.ddr3_wr_fifo_dat   (ddr3_wr_fifo_dat),
		.hdr_full           (hdr_full),
		.ddr3_wr_fifo_rd_en (ddr3_wr_fifo_rd_en),
		.hdr_push           (hdr_push),
		.hdr_word           (hdr_word),
		.ddr3_wr_sync_err   (ddr3_wr_sync_err),
		.wr_req             (wr_req.requester)
	);

	fill_header_fifo u_fill_header_fifo (
		.ddr3_domain_clk        (ddr3_domain_clk),
		.rst_n                  (rst_n),
		.hdr_push               (hdr_push),
		.hdr_word               (hdr_word),
		.fill_header_fifo_rd_en (fill_header_fifo_rd_en),
		.hdr_full               (hdr_full),
		.fill_header_fifo_empty (fill_header_fifo_empty),
		.fill_header_fifo_out   (fill_header_fifo_out)
	);

	burst_read_path u_burst_read_path (
		.ddr3_domain_clk     (ddr3_domain_clk),
		.rst_n               (rst_n),
		.ddr3_rd_one_burst   (ddr3_rd_one_burst),
		.ddr3_rd_burst_addr  (ddr3_rd_burst_addr),
		.app_rd_data_valid   (app_rd_data_valid),
		.app_rd_data         (app_rd_data),
		.ddr3_one_burst_rdy  (ddr3_one_burst_rdy),
		.ddr3_one_burst_data (ddr3_one_burst_data),
		.rd_req              (rd_req.requester)
	);

	ddr3_cmd_ctrl u_ddr3_cmd_ctrl (
		.ddr3_domain_clk   (ddr3_domain_clk),
		.rst_n             (rst_n),
		.app_rdy           (app_rdy),
		.app_rd_data_valid (app_rd_data_valid),
		.app_cmd_en        (app_cmd_en),
		.app_cmd_rd        (app_cmd_rd),
		.app_addr          (app_addr),
		.app_wdf_data      (app_wdf_data),
		.app_wdf_wren      (app_wdf_wren),
		.wr_req            (wr_req.ctrl),
		.rd_req            (rd_req.ctrl)
	);

endmodule

`default_nettype wire

// File: rtl/ddr3_intf_defs.svh
`ifndef DDR3_INTF_DEFS_SVH
`define DDR3_INTF_DEFS_SVH

// one stored word is one 128-bit burst of the x16 part
`define DDR3_DATA_W 128

// burst address, counts 128-bit bursts and not bytes
`define DDR3_ADDR_W 23

// top 16 bits of a fill header word
`define FILL_HDR_TAG 16'h4002

// headers waiting for the readout side
`define HDR_FIFO_DEPTH 8

// one sample lane of a data word
`define SAMPLE_W 32

// sample lanes per stored word
`define SAMPLES_PER_WORD 4

`endif

// File: rtl/ddr3_intf_pkg.sv
`default_nettype none

`include "ddr3_intf_defs.svh"

package ddr3_intf_pkg;

	// fill header as written by the acquisition side
	// 16 + 16 + 32 + 64 bits, msb first
	typedef struct packed {
		logic [15:0] tag;             // `FILL_HDR_TAG marks a header
		logic [15:0] fill_num;        // running fill number
		logic [31:0] word_count;      // data words after this header
		logic [63:0] timestamp;       // turn counter at fill start
	} fill_header_t;

	// one stored word, read as a header or as raw samples
	typedef union packed {
		fill_header_t hdr;
		logic [`SAMPLES_PER_WORD-1:0][`SAMPLE_W-1:0] samples;   // lane 0 in the low bits
	} acq_word_u;

endpackage

`default_nettype wire

// File: rtl/fill_header_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "ddr3_intf_defs.svh"

module fill_header_fifo import ddr3_intf_pkg::*; (
	input  wire                    ddr3_domain_clk,
	input  wire                    rst_n,
	input  wire                    hdr_push,                // write side never pushes when full
	input  fill_header_t           hdr_word,
	input  wire                    fill_header_fifo_rd_en,  // drop the head
	output logic                   hdr_full,
	output logic                   fill_header_fifo_empty,
	output logic [`DDR3_DATA_W-1:0] fill_header_fifo_out    // head word, fwft
);

	localparam int DEPTH = `HDR_FIFO_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	fill_header_t     mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;       // entries held
	logic             do_push;
	logic             do_pop;

	assign do_push = hdr_push && !hdr_full;
	assign do_pop  = fill_header_fifo_rd_en && !fill_header_fifo_empty;

	assign hdr_full               = (count == CNT_W'(DEPTH));
	assign fill_header_fifo_empty = (count == '0);   // registered count, head shows a cycle later
	assign fill_header_fifo_out   = mem[rd_ptr];

	always_ff @(posedge ddr3_domain_clk) begin
		if (do_push)
			mem[wr_ptr] <= hdr_word;
	end

	always_ff @(posedge ddr3_domain_clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;     // both or neither
			endcase
		end
	end

endmodule

`default_nettype wire

// File: rtl/mem_req_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "ddr3_intf_defs.svh"

// one requester's path into the command controller
// req is a level held with rd/addr/wdata until grant
interface mem_req_if;

	logic                    req;     // command pending
	logic                    rd;      // 1 read, 0 write
	logic [`DDR3_ADDR_W-1:0] addr;    // burst address
	logic [`DDR3_DATA_W-1:0] wdata;   // write burst
	logic                    grant;   // pulse, command taken by the app port

	modport requester (
		output req,
		output rd,
		output addr,
		output wdata,
		input  grant
	);

	modport ctrl (
		input  req,
		input  rd,
		input  addr,
		input  wdata,
		output grant
	);

endinterface

`default_nettype wire

// File: verification/app_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "ddr3_intf_defs.svh"

// behavioral memory behind the application port
// random ready stalls, one read in flight, latency 2 to 9 cycles
module app_mem_model (
	input  wire                     ddr3_domain_clk,
	input  wire                     rst_n,
	input  wire                     app_cmd_en,
	input  wire                     app_cmd_rd,
	input  wire  [`DDR3_ADDR_W-1:0] app_addr,
	input  wire  [`DDR3_DATA_W-1:0] app_wdf_data,
	input  wire                     app_wdf_wren,
	output logic                    app_rdy,
	output logic                    app_rd_data_valid,
	output logic [`DDR3_DATA_W-1:0] app_rd_data
);

	logic [`DDR3_DATA_W-1:0] mem [int];          // sparse, only written bursts
	integer                  seed = 32'hc4c88796;
	logic                    acc_rd = 1'b0;       // read taken at the last rising edge
	logic [`DDR3_ADDR_W-1:0] acc_addr = '0;
	logic [`DDR3_ADDR_W-1:0] rd_addr = '0;
	int                      rd_delay = 0;        // cycles left until data valid

	// never-written bursts read back a pattern built from the whole address
	function automatic logic [`DDR3_DATA_W-1:0] fill_word(input logic [`DDR3_ADDR_W-1:0] a);
		return {4{9'h1a5, a}};
	endfunction

	initial begin
		app_rdy           = 1'b0;
		app_rd_data_valid = 1'b0;
		app_rd_data       = '0;
	end

	// commands are taken on the rising edge
	always @(posedge ddr3_domain_clk) begin
		acc_rd   <= rst_n && app_cmd_en && app_rdy && app_cmd_rd;
		acc_addr <= app_addr;
		if (rst_n && app_cmd_en && app_rdy && app_wdf_wren)
			mem[app_addr] = app_wdf_data;
	end

	// responses change on the falling edge
	always @(negedge ddr3_domain_clk) begin
		app_rd_data_valid <= 1'b0;   // single cycle pulse
		if (!rst_n) begin
			app_rdy  <= 1'b0;
			rd_delay = 0;
		end else begin
			app_rdy <= ({$random(seed)} % 4) != 0;   // stall about one cycle in four
			if (rd_delay != 0) begin
				rd_delay = rd_delay - 1;
				if (rd_delay == 0) begin
					app_rd_data_valid <= 1'b1;
					app_rd_data       <= mem.exists(rd_addr) ? mem[rd_addr] : fill_word(rd_addr);
				end
			end
			if (acc_rd) begin
				rd_addr  = acc_addr;
				rd_delay = 1 + ({$random(seed)} % 8);   // 2..9 cycles after acceptance
			end
		end
	end

endmodule

`default_nettype wire

// File: verification/ddr3_intf_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "ddr3_intf_defs.svh"

module ddr3_intf_tb import ddr3_intf_pkg::*; ();

	localparam logic [1:0] OP_FILL    = 2'd0;   // well framed fill
	localparam logic [1:0] OP_BAD     = 2'd1;   // one data word more than declared
	localparam logic [1:0] OP_READ    = 2'd2;
	localparam logic [1:0] OP_RESTART = 2'd3;   // new acq_enabled edge
	localparam int         NROWS      = 13;

	typedef struct packed {
		logic [1:0]              op;
		logic [15:0]             fill_num;
		logic [15:0]             word_count;
		logic [`DDR3_ADDR_W-1:0] rd_addr;
		logic                    exp_err;   // sync error after the row
	} row_t;

	row_t rows [0:NROWS-1] = '{
		'{OP_FILL,    16'd1, 16'd3, 23'd0,  1'b0},   // addresses 0..3
		'{OP_FILL,    16'd2, 16'd5, 23'd0,  1'b0},   // addresses 4..9
		'{OP_READ,    16'd0, 16'd0, 23'd0,  1'b0},
		'{OP_READ,    16'd0, 16'd0, 23'd7,  1'b0},
		'{OP_READ,    16'd0, 16'd0, 23'd9,  1'b0},
		'{OP_RESTART, 16'd0, 16'd0, 23'd0,  1'b0},
		'{OP_FILL,    16'd3, 16'd2, 23'd0,  1'b0},   // overwrites 0..2
		'{OP_READ,    16'd0, 16'd0, 23'd0,  1'b0},
		'{OP_READ,    16'd0, 16'd0, 23'd2,  1'b0},
		'{OP_BAD,     16'd4, 16'd4, 23'd0,  1'b1},   // 3..8, extra word trips the check
		'{OP_FILL,    16'd5, 16'd1, 23'd0,  1'b1},   // error is sticky
		'{OP_READ,    16'd0, 16'd0, 23'd5,  1'b1},
		'{OP_READ,    16'd0, 16'd0, 23'd10, 1'b1}
	};

	logic                    ddr3_domain_clk;
	logic                    rst_n;
	logic                    acq_enabled;
	logic                    ddr3_wr_fifo_empty = 1'b1;
	logic [`DDR3_DATA_W-1:0] ddr3_wr_fifo_dat = '0;
	logic                    ddr3_wr_fifo_rd_en;
	logic                    ddr3_wr_sync_err;
	logic                    fill_header_fifo_rd_en;
	logic                    fill_header_fifo_empty;
	logic [`DDR3_DATA_W-1:0] fill_header_fifo_out;
	logic [`DDR3_ADDR_W-1:0] ddr3_rd_burst_addr;
	logic                    ddr3_rd_one_burst;
	logic                    ddr3_one_burst_rdy;
	logic [`DDR3_DATA_W-1:0] ddr3_one_burst_data;
	logic                    app_cmd_en;
	logic                    app_cmd_rd;
	logic [`DDR3_ADDR_W-1:0] app_addr;
	logic [`DDR3_DATA_W-1:0] app_wdf_data;
	logic                    app_wdf_wren;
	logic                    app_rdy;
	logic                    app_rd_data_valid;
	logic [`DDR3_DATA_W-1:0] app_rd_data;

	logic [`DDR3_DATA_W-1:0] fifo_q [$];          // write fifo contents, head at 0
	logic [`DDR3_DATA_W-1:0] exp_hdr [$];         // headers in push order
	logic [`DDR3_DATA_W-1:0] exp_words [int];     // expected burst per address
	logic                    popped = 1'b0;       // pop strobe seen at the last rising edge
	int                      push_idx = 0;        // words pushed since acquisition start
	int                      wr_idx = 0;          // writes seen since acquisition start
	int                      r;

	ddr3_intf DUT (.*);

	app_mem_model u_mem (
		.ddr3_domain_clk   (ddr3_domain_clk),
		.rst_n             (rst_n),
		.app_cmd_en        (app_cmd_en),
		.app_cmd_rd        (app_cmd_rd),
		.app_addr          (app_addr),
		.app_wdf_data      (app_wdf_data),
		.app_wdf_wren      (app_wdf_wren),
		.app_rdy           (app_rdy),
		.app_rd_data_valid (app_rd_data_valid),
		.app_rd_data       (app_rd_data)
	);

	initial begin
		ddr3_domain_clk = 1'b0;
		forever #5 ddr3_domain_clk = ~ddr3_domain_clk;
	end

	task automatic check_value(input string what, input logic [127:0] got,
			input logic [127:0] exp);
		if (got !== exp) begin
			$display("** Error at %0t ns: %s, got %h expected %h", $time, what, got, exp);
			$display("SIMULATION FAILED");
			$fatal(1, "mismatch on %s", what);
		end
	endtask

	function automatic logic [127:0] make_header(input int fnum, input int cnt);
		acq_word_u w;
		w.hdr.tag        = `FILL_HDR_TAG;
		w.hdr.fill_num   = fnum[15:0];
		w.hdr.word_count = cnt;
		w.hdr.timestamp  = 64'h0badcafe_00000000 | fnum;   // distinct per fill
		return w;
	endfunction

	// top nibble 4'hd keeps data words clear of the header tag
	function automatic logic [127:0] make_data(input int fnum, input int idx);
		acq_word_u w;
		for (int k = 0; k < `SAMPLES_PER_WORD; k++)
			w.samples[k] = {4'hd, 4'(k), 8'(fnum), 16'(idx)};
		return w;
	endfunction

	// write fifo, fwft view driven on the falling edge
	always @(posedge ddr3_domain_clk) popped <= ddr3_wr_fifo_rd_en;
	always @(negedge ddr3_domain_clk) begin
		if (popped)
			void'(fifo_q.pop_front());
		ddr3_wr_fifo_empty <= (fifo_q.size() == 0);
		ddr3_wr_fifo_dat   <= (fifo_q.size() != 0) ? fifo_q[0] : '0;
	end

	// every accepted write must be the next word in order, no gaps or repeats
	always @(posedge ddr3_domain_clk) begin
		if (rst_n && app_cmd_en && app_rdy) begin
			if (app_cmd_rd) begin
				check_value("write strobe on a read", app_wdf_wren, 1'b0);
				check_value("read address", app_addr, ddr3_rd_burst_addr);   // the requested burst
			end else begin
				check_value("write strobe", app_wdf_wren, 1'b1);
				check_value("write beyond pushed words", wr_idx < push_idx, 1'b1);
				check_value("write address", app_addr, wr_idx);
				check_value("write data", app_wdf_data, exp_words[wr_idx]);
				wr_idx++;
			end
		end
	end

	task automatic push_word(input logic [127:0] w);
		fifo_q.push_back(w);
		exp_words[push_idx] = w;   // n-th word lands at address n
		push_idx++;
	endtask

	task automatic send_fill(input int fnum, input int cnt, input int extra);
		logic [127:0] h;
		h = make_header(fnum, cnt);
		@(posedge ddr3_domain_clk);
		exp_hdr.push_back(h);
		push_word(h);
		for (int i = 0; i < cnt + extra; i++)
			push_word(make_data(fnum, i));
		while (wr_idx != push_idx)
			@(negedge ddr3_domain_clk);   // all words written
	endtask

	task automatic read_burst(input logic [`DDR3_ADDR_W-1:0] addr);
		logic [127:0] held;
		@(negedge ddr3_domain_clk);
		ddr3_rd_burst_addr = addr;
		ddr3_rd_one_burst  = 1'b1;
		do @(negedge ddr3_domain_clk); while (!ddr3_one_burst_rdy);
		check_value("read data", ddr3_one_burst_data, exp_words[addr]);
		held = ddr3_one_burst_data;
		repeat (3) begin
			@(negedge ddr3_domain_clk);
			check_value("burst ready held", ddr3_one_burst_rdy, 1'b1);
			check_value("burst data held", ddr3_one_burst_data, held);
		end
		ddr3_rd_one_burst = 1'b0;
		@(negedge ddr3_domain_clk);
		check_value("burst ready released", ddr3_one_burst_rdy, 1'b0);
	endtask

	task automatic restart_acq;
		@(negedge ddr3_domain_clk);
		acq_enabled = 1'b0;
		repeat (2) @(negedge ddr3_domain_clk);
		acq_enabled = 1'b1;
		push_idx    = 0;   // storage starts over at address 0
		wr_idx      = 0;
	endtask

	task automatic drain_headers;
		while (exp_hdr.size() != 0) begin
			@(negedge ddr3_domain_clk);
			check_value("header fifo empty flag", fill_header_fifo_empty, 1'b0);
			check_value("header word", fill_header_fifo_out, exp_hdr.pop_front());
			fill_header_fifo_rd_en = 1'b1;
			@(negedge ddr3_domain_clk);
			fill_header_fifo_rd_en = 1'b0;
		end
		check_value("header fifo empty after drain", fill_header_fifo_empty, 1'b1);
	endtask

	// watchdog, budget from the table
	initial begin
		int limit;
		limit = 16 + 150;   // reset, restart and header drain slack
		for (int n = 0; n < NROWS; n++) begin
			if (rows[n].op == OP_READ)
				limit += 40;
			else if (rows[n].op != OP_RESTART)
				limit += 30 * (rows[n].word_count + 2);   // header and a possible extra word
		end
		repeat (limit) @(posedge ddr3_domain_clk);
		$display("timeout: the run did not finish within %0d clock cycles", limit);
		$display("SIMULATION FAILED");
		$fatal(1, "watchdog expired");
	end

	initial begin
		rst_n                  = 1'b0;
		acq_enabled            = 1'b0;
		fill_header_fifo_rd_en = 1'b0;
		ddr3_rd_burst_addr     = '0;
		ddr3_rd_one_burst      = 1'b0;
		repeat (16) @(negedge ddr3_domain_clk);
		check_value("app_cmd_en in reset", app_cmd_en, 1'b0);
		check_value("app_wdf_wren in reset", app_wdf_wren, 1'b0);
		check_value("fifo rd_en in reset", ddr3_wr_fifo_rd_en, 1'b0);
		check_value("burst ready in reset", ddr3_one_burst_rdy, 1'b0);
		check_value("sync error in reset", ddr3_wr_sync_err, 1'b0);
		check_value("header fifo empty in reset", fill_header_fifo_empty, 1'b1);
		rst_n = 1'b1;
		@(negedge ddr3_domain_clk);
		acq_enabled = 1'b1;
		for (r = 0; r < NROWS; r++) begin
			case (rows[r].op)
				OP_FILL: send_fill(rows[r].fill_num, rows[r].word_count, 0);
				OP_BAD:  send_fill(rows[r].fill_num, rows[r].word_count, 1);
				OP_READ: read_burst(rows[r].rd_addr);
				default: restart_acq();
			endcase
			check_value("sync error", ddr3_wr_sync_err, rows[r].exp_err);
		end
		drain_headers();
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

`default_nettype wire
